//--- design/mdu_pkg.sv
// RV32M multiply/divide unit shared definitions
// Word types, funct3 operation codes and the divider FSM states

package mdu_pkg;

  // Data width, RV32 only
  localparam int XLEN = 32;

  // Operand and result word
  typedef logic [XLEN-1:0] xlen_t;

  // Full product, divider partial remainder plus quotient
  typedef logic [2*XLEN-1:0] dword_t;

  // funct3 of the M-extension opcode
  typedef logic [2:0] op_t;

  // M-extension operations in funct3 order
  // Bit 2 set selects the divider
  localparam op_t OP_MUL    = 3'd0;  // Low half, sign irrelevant
  localparam op_t OP_MULH   = 3'd1;  // High half, signed x signed
  localparam op_t OP_MULHSU = 3'd2;  // High half, signed x unsigned
  localparam op_t OP_MULHU  = 3'd3;  // High half, unsigned x unsigned
  localparam op_t OP_DIV    = 3'd4;  // Signed quotient
  localparam op_t OP_DIVU   = 3'd5;  // Unsigned quotient
  localparam op_t OP_REM    = 3'd6;  // Signed remainder
  localparam op_t OP_REMU   = 3'd7;  // Unsigned remainder

  // Iterative divider states
  typedef enum logic [1:0] {
    DIV_IDLE,  // Waiting for div_start
    DIV_RUN,   // Shift-subtract iterations
    DIV_FIX,   // Sign correction of quotient/remainder
    DIV_DONE   // Result valid, done pulse
  } div_state_t;

endpackage

//--- design/mdu_decode.sv
// M-extension operation decode
// Accepts a start while idle, splits funct3 into unit select and
// sign/half modes, and keeps the busy flag until a unit finishes

`timescale 1ns/100ps

module mdu_decode (
  input  logic          clk,
  input  logic          reset,
  input  logic          start,
  input  mdu_pkg::op_t  operation,
  input  logic          mul_done,
  input  logic          div_done,
  output logic          mul_start,
  output logic          div_start,
  output logic          mul_signed_a,
  output logic          mul_signed_b,
  output logic          mul_high,
  output logic          div_signed,
  output logic          div_rem,
  output logic          busy
);

  logic accept;  // Start seen while idle

  // Starts during busy are dropped
  assign accept = start & ~busy;

  // Control flags, one-cycle start pulses
  always_ff @(posedge clk) begin
    if (reset) begin
      mul_start <= 1'b0;
      div_start <= 1'b0;
      busy      <= 1'b0;
    end else begin
      mul_start <= accept & ~operation[2];
      div_start <= accept & operation[2];
      if (accept)
        busy <= 1'b1;
      else if (mul_done | div_done)
        busy <= 1'b0;  // Same edge that raises ready
    end
  end

  // Mode bits held until the next accepted start
  always_ff @(posedge clk) begin
    if (accept) begin
      mul_signed_a <= 1'b0;
      mul_signed_b <= 1'b0;
      mul_high     <= 1'b0;
      div_signed   <= 1'b0;
      div_rem      <= 1'b0;
      case (operation)
        mdu_pkg::OP_MUL:    mul_high <= 1'b0;  // Low half only
        mdu_pkg::OP_MULH: begin
          mul_signed_a <= 1'b1;
          mul_signed_b <= 1'b1;
          mul_high     <= 1'b1;
        end
        mdu_pkg::OP_MULHSU: begin
          mul_signed_a <= 1'b1;  // rs2 stays unsigned
          mul_high     <= 1'b1;
        end
        mdu_pkg::OP_MULHU:  mul_high <= 1'b1;
        mdu_pkg::OP_DIV:    div_signed <= 1'b1;
        mdu_pkg::OP_DIVU:   div_signed <= 1'b0;
        mdu_pkg::OP_REM: begin
          div_signed <= 1'b1;
          div_rem    <= 1'b1;
        end
        mdu_pkg::OP_REMU:   div_rem <= 1'b1;
        default:            div_rem <= 1'b0;
      endcase
    end
  end

endmodule

//--- design/mul_unit.sv
// Two-cycle 32x32 multiplier for MUL, MULH, MULHSU and MULHU
// Operands extended to 33 bits per sign flag, 64-bit product registered,
// low or high half returned with a one-cycle done pulse

`timescale 1ns/100ps

module mul_unit (
  input  logic           clk,
  input  logic           reset,
  input  logic           mul_start,
  input  logic           mul_signed_a,
  input  logic           mul_signed_b,
  input  logic           mul_high,
  input  mdu_pkg::xlen_t operand_a,
  input  mdu_pkg::xlen_t operand_b,
  output mdu_pkg::xlen_t mul_product,
  output logic           mul_done
);

  // Stage 1 operand registers
  mdu_pkg::xlen_t op_a_q;
  mdu_pkg::xlen_t op_b_q;

  // Stage 2 full product
  mdu_pkg::dword_t prod_q;

  // Extended operands and raw product
  logic signed [mdu_pkg::XLEN:0]     ext_a;
  logic signed [mdu_pkg::XLEN:0]     ext_b;
  logic signed [2*mdu_pkg::XLEN+1:0] full_prod;  // 66 bits, top two unused

  // Operands captured every edge, so the copy taken on the
  // accepting edge is the one in place when mul_start arrives
  always_ff @(posedge clk) begin
    op_a_q <= operand_a;
    op_b_q <= operand_b;
  end

  // Sign or zero extension to 33 bits
  assign ext_a = {mul_signed_a & op_a_q[mdu_pkg::XLEN-1], op_a_q};
  assign ext_b = {mul_signed_b & op_b_q[mdu_pkg::XLEN-1], op_b_q};

  // Signed 33x33 covers all four sign mixes
  assign full_prod = ext_a * ext_b;

  // Product held until the next multiply
  always_ff @(posedge clk) begin
    if (mul_start)
      prod_q <= full_prod[2*mdu_pkg::XLEN-1:0];
  end

  // Done one cycle after mul_start
  always_ff @(posedge clk) begin
    if (reset)
      mul_done <= 1'b0;
    else
      mul_done <= mul_start;
  end

  // Half select, mode bit stable while busy
  assign mul_product = mul_high ? prod_q[2*mdu_pkg::XLEN-1:mdu_pkg::XLEN]
                                : prod_q[mdu_pkg::XLEN-1:0];

endmodule

//--- design/div_unit.sv
// Iterative restoring divider for DIV, DIVU, REM and REMU
// One load, 32 shift-subtract steps, one sign fix-up; divide by zero
// and signed overflow skip straight to the done state

`timescale 1ns/100ps

module div_unit (
  input  logic           clk,
  input  logic           reset,
  input  logic           div_start,
  input  logic           div_signed,
  input  logic           div_rem,
  input  mdu_pkg::xlen_t operand_a,
  input  mdu_pkg::xlen_t operand_b,
  output mdu_pkg::xlen_t div_quot_rem,
  output logic           div_done
);

  mdu_pkg::div_state_t state;
  logic [5:0]          count;  // Iteration index 0..31

  mdu_pkg::xlen_t  op_a_q;     // Dividend as accepted
  mdu_pkg::xlen_t  op_b_q;     // Divisor as accepted
  mdu_pkg::xlen_t  divisor_q;  // Divisor magnitude
  mdu_pkg::dword_t rem_q;      // {partial remainder, quotient}
  logic            quot_neg_q;
  logic            rem_neg_q;

  logic            a_neg;
  logic            b_neg;
  mdu_pkg::xlen_t  mag_a;
  mdu_pkg::xlen_t  mag_b;
  logic            div_by_zero;
  logic            signed_ovf;
  logic [mdu_pkg::XLEN:0] part_rem;  // Remainder shifted left, 33 bits
  logic [mdu_pkg::XLEN:0] trial;     // part_rem minus divisor
  mdu_pkg::xlen_t  quot;
  mdu_pkg::xlen_t  rem;

  // Free-running capture, holds the accepting-edge operands at div_start
  always_ff @(posedge clk) begin
    op_a_q <= operand_a;
    op_b_q <= operand_b;
  end

  // Operand signs and magnitudes
  assign a_neg = div_signed & op_a_q[mdu_pkg::XLEN-1];
  assign b_neg = div_signed & op_b_q[mdu_pkg::XLEN-1];
  assign mag_a = a_neg ? -op_a_q : op_a_q;
  assign mag_b = b_neg ? -op_b_q : op_b_q;

  // ISA special cases
  assign div_by_zero = (op_b_q == '0);
  assign signed_ovf  = div_signed & (op_a_q == {1'b1, {(mdu_pkg::XLEN-1){1'b0}}})
                     & (op_b_q == '1);  // Most negative / -1

  // One restoring step
  assign part_rem = {rem_q[2*mdu_pkg::XLEN-1:mdu_pkg::XLEN], rem_q[mdu_pkg::XLEN-1]};
  assign trial    = part_rem - {1'b0, divisor_q};

  assign quot = rem_q[mdu_pkg::XLEN-1:0];
  assign rem  = rem_q[2*mdu_pkg::XLEN-1:mdu_pkg::XLEN];

  // FSM and iteration counter
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= mdu_pkg::DIV_IDLE;
      count <= '0;
    end else begin
      case (state)
        mdu_pkg::DIV_IDLE: begin
          count <= '0;
          if (div_start)
            state <= (div_by_zero | signed_ovf) ? mdu_pkg::DIV_DONE : mdu_pkg::DIV_RUN;
        end
        mdu_pkg::DIV_RUN: begin
          count <= count + 6'd1;
          if (count == 6'd31)
            state <= mdu_pkg::DIV_FIX;  // 32nd step done
        end
        mdu_pkg::DIV_FIX:  state <= mdu_pkg::DIV_DONE;
        mdu_pkg::DIV_DONE: state <= mdu_pkg::DIV_IDLE;
        default:           state <= mdu_pkg::DIV_IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    case (state)
      mdu_pkg::DIV_IDLE: begin
        if (div_start) begin
          rem_q      <= {{mdu_pkg::XLEN{1'b0}}, mag_a};  // Dividend in quotient half
          divisor_q  <= mag_b;
          quot_neg_q <= a_neg ^ b_neg;
          rem_neg_q  <= a_neg;  // Remainder follows dividend
          if (div_by_zero)
            div_quot_rem <= div_rem ? op_a_q : '1;
          else if (signed_ovf)
            div_quot_rem <= div_rem ? '0 : op_a_q;
        end
      end
      mdu_pkg::DIV_RUN: begin
        if (!trial[mdu_pkg::XLEN])  // No borrow, subtract fits
          rem_q <= {trial[mdu_pkg::XLEN-1:0], rem_q[mdu_pkg::XLEN-2:0], 1'b1};
        else                        // Restore
          rem_q <= {part_rem[mdu_pkg::XLEN-1:0], rem_q[mdu_pkg::XLEN-2:0], 1'b0};
      end
      mdu_pkg::DIV_FIX: begin
        if (div_rem)
          div_quot_rem <= rem_neg_q ? -rem : rem;
        else
          div_quot_rem <= quot_neg_q ? -quot : quot;
      end
      default: ;  // DIV_DONE holds the result
    endcase
  end

  // Single-cycle done state
  assign div_done = (state == mdu_pkg::DIV_DONE);

endmodule

//--- design/mdu_result.sv
// Result stage of the multiply/divide unit
// Registers the finishing unit's value and pulses ready for one cycle,
// then holds the result until the next completion

`timescale 1ns/100ps

module mdu_result (
  input  logic           clk,
  input  logic           reset,
  input  logic           mul_done,
  input  mdu_pkg::xlen_t mul_product,
  input  logic           div_done,
  input  mdu_pkg::xlen_t div_quot_rem,
  output mdu_pkg::xlen_t result,
  output logic           ready
);

  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0;
      ready  <= 1'b0;
    end else begin
      ready <= mul_done | div_done;  // One pulse per completion
      // Done pulses never overlap, busy blocks a second start
      if (mul_done | div_done)
        result <= div_done ? div_quot_rem : mul_product;  // Else held for a late read
    end
  end

endmodule

//--- design/mul_div_unit.sv
// RV32M execution unit top level
// Decode, two-cycle multiplier, iterative divider and result register

`timescale 1ns/100ps

module mul_div_unit (
  input  logic           clk,
  input  logic           reset,
  input  logic           start,       // Launch strobe
  input  mdu_pkg::op_t   operation,   // funct3
  input  mdu_pkg::xlen_t operand_a,   // rs1
  input  mdu_pkg::xlen_t operand_b,   // rs2
  output mdu_pkg::xlen_t result,
  output logic           busy,
  output logic           ready        // One-cycle completion pulse
);

  // Decode to units
  logic mul_start;
  logic div_start;
  logic mul_signed_a;
  logic mul_signed_b;
  logic mul_high;
  logic div_signed;
  logic div_rem;

  // Units to result stage
  mdu_pkg::xlen_t mul_product;
  mdu_pkg::xlen_t div_quot_rem;
  logic           mul_done;
  logic           div_done;

  mdu_decode decode_inst (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .operation    (operation),
    .mul_done     (mul_done),
    .div_done     (div_done),
    .mul_start    (mul_start),
    .div_start    (div_start),
    .mul_signed_a (mul_signed_a),
    .mul_signed_b (mul_signed_b),
    .mul_high     (mul_high),
    .div_signed   (div_signed),
    .div_rem      (div_rem),
    .busy         (busy)
  );

  mul_unit mul_inst (
    .clk          (clk),
    .reset        (reset),
    .mul_start    (mul_start),
    .mul_signed_a (mul_signed_a),
    .mul_signed_b (mul_signed_b),
    .mul_high     (mul_high),
    .operand_a    (operand_a),
    .operand_b    (operand_b),
    .mul_product  (mul_product),
    .mul_done     (mul_done)
  );

  div_unit div_inst (
    .clk          (clk),
    .reset        (reset),
    .div_start    (div_start),
    .div_signed   (div_signed),
    .div_rem      (div_rem),
    .operand_a    (operand_a),
    .operand_b    (operand_b),
    .div_quot_rem (div_quot_rem),
    .div_done     (div_done)
  );

  mdu_result result_inst (
    .clk          (clk),
    .reset        (reset),
    .mul_done     (mul_done),
    .mul_product  (mul_product),
    .div_done     (div_done),
    .div_quot_rem (div_quot_rem),
    .result       (result),
    .ready        (ready)
  );

endmodule

//--- verif/mul_div_unit_tb.sv
// Testbench for the RV32M multiply/divide unit
// LFSR and corner operands, own reference arithmetic, assertion checks

`timescale 1ns/100ps

module mul_div_unit_tb;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  localparam int N_RAND       = 16;  // Random operations per funct3
  localparam int MAX_WAIT     = 60;  // Cycles before a ready counts as lost
  // Corner pairs, random, divide by zero, overflow, ignored-start runs
  localparam int NUM_OPS      = 8 * 25 + 8 * N_RAND + 16 + 2 + 2;

  logic           clk = 1'b0;
  logic           reset = 1'b1;
  logic           start = 1'b0;
  mdu_pkg::op_t   operation = '0;
  mdu_pkg::xlen_t operand_a = '0;
  mdu_pkg::xlen_t operand_b = '0;
  mdu_pkg::xlen_t result;
  logic           busy;
  logic           ready;

  logic [31:0]    lfsr = 32'h2ca0_5b14;
  mdu_pkg::xlen_t corners [0:4] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
  int             value_errors = 0;
  int             protocol_errors = 0;

  mul_div_unit mul_div_unit_inst (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .operation (operation),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .result    (result),
    .busy      (busy),
    .ready     (ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      w = {w[30:0], lfsr[0]};
    end
    return w;
  endfunction

  // ISA results from 64-bit products and the divide rules
  function automatic mdu_pkg::xlen_t expected_result(input mdu_pkg::op_t op,
                                                     input mdu_pkg::xlen_t a,
                                                     input mdu_pkg::xlen_t b);
    mdu_pkg::dword_t   prod;
    logic signed [31:0] qs;
    logic signed [31:0] rs;
    logic              ovf;
    mdu_pkg::xlen_t    r;
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    qs = '0;
    rs = '0;
    if (b != 0 && !ovf) begin
      qs = $signed(a) / $signed(b);  // Truncates toward zero
      rs = $signed(a) % $signed(b);  // Sign of dividend
    end
    case (op)
      mdu_pkg::OP_MULH:   prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
      mdu_pkg::OP_MULHSU: prod = {{32{a[31]}}, a} * {32'h0, b};
      default:            prod = {32'h0, a} * {32'h0, b};  // MUL, MULHU
    endcase
    case (op)
      mdu_pkg::OP_MUL:  r = prod[31:0];
      mdu_pkg::OP_DIV:  r = (b == 0) ? 32'hffff_ffff : (ovf ? a : qs);
      mdu_pkg::OP_DIVU: r = (b == 0) ? 32'hffff_ffff : a / b;
      mdu_pkg::OP_REM:  r = (b == 0) ? a : (ovf ? 32'h0 : rs);
      mdu_pkg::OP_REMU: r = (b == 0) ? a : a % b;
      default:          r = prod[63:32];  // High-half multiplies
    endcase
    return r;
  endfunction

  // One operation from launch to ready; intrude raises a second start while busy
  task automatic run_op(input mdu_pkg::op_t op, input mdu_pkg::xlen_t a,
                        input mdu_pkg::xlen_t b, input bit intrude);
    mdu_pkg::xlen_t expected;
    string          name;
    int             edges;
    int             want_edges;
    expected = expected_result(op, a, b);
    name = $sformatf("funct3=%0d a=%h b=%h", op, a, b);
    // Multiplies and ISA special divides have a fixed latency
    if (!op[2] || b == 0 || (!op[0] && a == 32'h8000_0000 && b == 32'hffff_ffff))
      want_edges = 2;
    else
      want_edges = 0;  // Normal divide, no count assumed
    @(negedge clk);
    assert (!busy) else begin
      protocol_errors++;
      $display("Unit still busy when %s was launched", name);
    end
    start = 1'b1;
    operation = op;
    operand_a = a;
    operand_b = b;
    @(negedge clk);  // Accepting edge has passed
    start = 1'b0;
    if (intrude) begin
      start = 1'b1;  // Sampled once, while busy
      operation = op ^ 3'b100;  // Other unit
      operand_a = random_bits(32);
      operand_b = random_bits(32);
    end
    edges = 0;
    while (!ready && edges < MAX_WAIT) begin
      assert (busy) else begin
        protocol_errors++;
        $display("busy low before ready for %s", name);
      end
      @(negedge clk);
      start = 1'b0;
      edges++;
    end
    if (!ready) begin
      protocol_errors++;
      $display("No ready pulse within %0d cycles for %s", MAX_WAIT, name);
    end else begin
      assert (result == expected) else begin
        value_errors++;
        $display("error %s: expected %h, got %h", name, expected, result);
      end
      assert (want_edges == 0 || edges == want_edges) else begin
        value_errors++;
        $display("error %s latency: expected %0d, got %0d", name, want_edges, edges);
      end
      assert (!busy) else begin
        protocol_errors++;
        $display("busy still high in the ready cycle of %s", name);
      end
    end
  endtask

  // Start low, so result must hold and no ready may appear
  task automatic hold_check(input int cycles);
    mdu_pkg::xlen_t held;
    held = result;
    repeat (cycles) begin
      @(negedge clk);
      assert (!ready) else begin
        protocol_errors++;
        $display("Extra ready pulse while start stayed low");
      end
      assert (result == held) else begin
        value_errors++;
        $display("error hold: expected %h, got %h", held, result);
      end
    end
  endtask

  // Ready is a single-cycle pulse
  assert property (@(posedge clk) disable iff (reset) ready |=> !ready)
    else begin
      protocol_errors++;
      $display("ready stayed high for more than one cycle");
    end

  // busy drops on the edge that raises ready
  assert property (@(posedge clk) disable iff (reset) $rose(ready) |-> $fell(busy))
    else begin
      protocol_errors++;
      $display("busy did not fall together with ready");
    end

  // result moves only with ready
  assert property (@(posedge clk) disable iff (reset) !ready |-> $stable(result))
    else begin
      protocol_errors++;
      $display("result changed without a ready pulse");
    end

  initial begin
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    assert (!busy && !ready && result == '0) else begin
      protocol_errors++;
      $display("Outputs not cleared after reset");
    end
    // Corner pairs through every funct3
    for (int op = 0; op < 8; op++)
      for (int i = 0; i < 5; i++)
        for (int j = 0; j < 5; j++)
          run_op(mdu_pkg::op_t'(op), corners[i], corners[j], 1'b0);
    hold_check(6);
    for (int op = 0; op < 8; op++)
      for (int k = 0; k < N_RAND; k++)
        run_op(mdu_pkg::op_t'(op), random_bits(32), random_bits(32), 1'b0);
    hold_check(6);
    // Divide by zero with random dividends
    for (int op = 4; op < 8; op++)
      for (int k = 0; k < 4; k++)
        run_op(mdu_pkg::op_t'(op), random_bits(32), 32'h0, 1'b0);
    run_op(mdu_pkg::OP_DIV, 32'h8000_0000, 32'hffff_ffff, 1'b0);  // Signed overflow
    run_op(mdu_pkg::OP_REM, 32'h8000_0000, 32'hffff_ffff, 1'b0);
    hold_check(6);
    // Start while busy, longer than a divide
    run_op(mdu_pkg::OP_MULHU, random_bits(32), random_bits(32), 1'b1);
    hold_check(45);
    run_op(mdu_pkg::OP_DIV, random_bits(32), random_bits(32), 1'b1);
    hold_check(45);
    $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  // Watchdog, 40 cycles per operation plus reset
  initial begin
    #(NUM_OPS * 40 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD);
    $display("Timeout, the run did not finish in time");
    $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
    $display("Some tests failed");
    $finish;
  end

endmodule

//--- sources.f
design/mdu_pkg.sv
design/mdu_decode.sv
design/mul_unit.sv
design/div_unit.sv
design/mdu_result.sv
design/mul_div_unit.sv
verif/mul_div_unit_tb.sv

//--- Bender.yml
package:
  name: mul_div_unit

dependencies: {}

sources:
  # RTL, package first
  - design/mdu_pkg.sv
  - design/mdu_decode.sv
  - design/mul_unit.sv
  - design/div_unit.sv
  - design/mdu_result.sv
  - design/mul_div_unit.sv
  # Testbench
  - target: test
    files:
      - verif/mul_div_unit_tb.sv
